// File: list.f
hdl/cache_pkg.sv
hdl/cache_store.sv
hdl/cache_ctrl.sv
hdl/line_memory.sv
hdl/cache_subsys_top.sv
verification/tb_clock_gen.sv
verification/tb_cache_subsys.sv

// File: Bender.yml
package:
  name: cache_subsys

sources:
  - hdl/cache_pkg.sv
  - hdl/cache_store.sv
  - hdl/cache_ctrl.sv
  - hdl/line_memory.sv
  - hdl/cache_subsys_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_cache_subsys.sv

// File: verification/tb_cache_subsys.sv
module tb_cache_subsys;
    import cache_pkg::*;

    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * (MEM_LATENCY + 6) * 2;

    // What an operation is expected to do beyond returning data
    localparam int M_PLAIN   = 0;
    localparam int M_HIT_RD  = 1;
    localparam int M_MISS_RD = 2;
    localparam int M_WR_HIT  = 3;
    localparam int M_WR_MISS = 4;

    // Three tags of set 0 outside the random address range
    localparam logic [WORD_W-1:0] ADDR_A = 16'h0100;
    localparam logic [WORD_W-1:0] ADDR_B = 16'h0200;
    localparam logic [WORD_W-1:0] ADDR_C = 16'h0300;

    logic              clk;
    logic              arst_n;
    logic              rd_req;
    logic              wr_req;
    logic [WORD_W-1:0] req_addr;
    logic [WORD_W-1:0] req_wdata;
    logic [WORD_W-1:0] rdata;
    logic              ready;
    logic              mem_read;
    logic              mem_write;
    logic              mem_line;
    logic [WORD_W-1:0] mem_addr;

    // Every word written so far over a cleared memory
    logic [WORD_W-1:0] shadow [2**WORD_W] = '{default: '0};
    logic [WORD_W-1:0] exp_rdata;
    logic              chk_rd;
    logic              chk_hit_rd;
    logic              chk_miss_rd;
    logic              chk_wr_hit;
    logic              chk_wr_miss;

    integer            seed;
    logic [31:0]       r;
    logic [31:0]       d;
    logic [WORD_W-1:0] addr;
    logic [WORD_W-1:0] last_addr;
    logic              last_rd;
    logic              op_wr;
    int                op_mode;
    int                errors;
    int                n_ops;
    int                cycle_cnt;

    tb_clock_gen u_clk (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    cache_subsys_top DUT (
        .clk         (clk),
        .i_arst_n    (arst_n),
        .i_read      (rd_req),
        .i_write     (wr_req),
        .i_addr      (req_addr),
        .i_wdata     (req_wdata),
        .o_rdata     (rdata),
        .o_ready     (ready),
        .o_mem_read  (mem_read),
        .o_mem_write (mem_write),
        .o_mem_line  (mem_line),
        .o_mem_addr  (mem_addr)
    );

    task automatic report_mismatch(input string name, input logic [WORD_W-1:0] exp,
                                   input logic [WORD_W-1:0] act);
        errors++;
        $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act);
    endtask

    task automatic flag_violation(input string msg);
        errors++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    // One request held until o_ready returns and then one idle cycle
    task automatic run_op(input logic wr, input logic [WORD_W-1:0] a,
                          input logic [WORD_W-1:0] data, input int mode);
        if (mode == M_WR_HIT || mode == M_WR_MISS) begin
            // Checked writes start with the memory idle
            while (mem_write) begin
                @(posedge clk);
                #1;
            end
        end
        chk_rd      = !wr;
        chk_hit_rd  = (mode == M_HIT_RD);
        chk_miss_rd = (mode == M_MISS_RD);
        chk_wr_hit  = (mode == M_WR_HIT);
        chk_wr_miss = (mode == M_WR_MISS);
        if (wr) begin
            shadow[a] = data;
        end else begin
            exp_rdata = shadow[a];
        end
        rd_req    = !wr;
        wr_req    = wr;
        req_addr  = a;
        req_wdata = data;
        @(posedge clk);
        #1;
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        rd_req = 1'b0;
        wr_req = 1'b0;
        @(posedge clk);
        #1;
        n_ops++;
    endtask

    a_reset_state: assert property (@(posedge clk)
        !arst_n && (cycle_cnt > 0) |-> ({ready, mem_read, mem_write} == 3'b100))
        else report_mismatch("{o_ready,o_mem_read,o_mem_write}", 16'h4,
                             16'($sampled({ready, mem_read, mem_write})));

    a_read_data: assert property (@(posedge clk) disable iff (!arst_n)
        chk_rd && $rose(ready) |-> (rdata == exp_rdata))
        else report_mismatch("o_rdata", $sampled(exp_rdata), $sampled(rdata));

    a_hit_no_fill: assert property (@(posedge clk) disable iff (!arst_n)
        chk_hit_rd |-> !mem_read)
        else report_mismatch("o_mem_read", 16'h0, 16'($sampled(mem_read)));

    a_hit_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        chk_hit_rd && $fell(ready) |=> ready)
        else report_mismatch("o_ready", 16'h1, 16'($sampled(ready)));

    a_miss_fill: assert property (@(posedge clk) disable iff (!arst_n)
        chk_miss_rd && $fell(ready) |=> mem_read)
        else report_mismatch("o_mem_read", 16'h1, 16'($sampled(mem_read)));

    // Ready back after one cycle with an aligned line write under way
    a_write_hit: assert property (@(posedge clk) disable iff (!arst_n)
        chk_wr_hit && $fell(ready)
        |=> ({ready, mem_write, mem_line, mem_addr[1:0]} == 5'b11100))
        else report_mismatch("{o_ready,o_mem_write,o_mem_line,o_mem_addr[1:0]}", 16'h1c,
                             16'($sampled({ready, mem_write, mem_line, mem_addr[1:0]})));

    a_write_miss: assert property (@(posedge clk) disable iff (!arst_n)
        chk_wr_miss && $fell(ready) |=> ({mem_write, mem_line} == 2'b10))
        else report_mismatch("{o_mem_write,o_mem_line}", 16'h2,
                             16'($sampled({mem_write, mem_line})));

    a_mem_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_read && mem_write))
        else flag_violation("memory read and write requested together");

    // A request level that stays high keeps describing the same request
    a_mem_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_read && $past(mem_read)) || (mem_write && $past(mem_write))
        |-> $stable({mem_line, mem_addr}))
        else flag_violation("new memory request raised while another was high");

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles: %0d ops done, %0d errors",
                 cycle_cnt, n_ops, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rd_req      = 1'b0;
        wr_req      = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        exp_rdata   = '0;
        chk_rd      = 1'b0;
        chk_hit_rd  = 1'b0;
        chk_miss_rd = 1'b0;
        chk_wr_hit  = 1'b0;
        chk_wr_miss = 1'b0;
        last_rd     = 1'b0;
        last_addr   = '0;
        errors      = 0;
        n_ops       = 0;
        seed        = 32'h2d78;
        @(posedge arst_n);
        @(posedge clk);
        #1;

        // A and B fill set 0 and C evicts B once A is touched
        run_op(1'b0, ADDR_A, '0, M_MISS_RD);
        run_op(1'b0, ADDR_B, '0, M_MISS_RD);
        run_op(1'b0, ADDR_A, '0, M_HIT_RD);
        run_op(1'b0, ADDR_C, '0, M_MISS_RD);
        run_op(1'b0, ADDR_A, '0, M_HIT_RD);
        run_op(1'b0, ADDR_B, '0, M_MISS_RD);

        for (int i = 0; i < NUM_OPS; i++) begin
            r = $random(seed);
            d = $random(seed);
            // Eight tags in each of the two sets
            addr    = r[15:0] & 16'h003f;
            op_wr   = 1'b0;
            op_mode = M_PLAIN;
            case (r[18:16])
                3'd3: begin
                    if (last_rd) begin
                        addr    = last_addr;
                        op_mode = M_HIT_RD;
                    end
                end
                3'd4: begin
                    op_wr = 1'b1;
                    if (last_rd) begin
                        addr    = last_addr;
                        op_mode = M_WR_HIT;
                    end
                end
                3'd5: begin
                    // Never read and thus never cached
                    op_wr   = 1'b1;
                    addr    = {4'h8, r[31:20]};
                    op_mode = M_WR_MISS;
                end
                3'd6, 3'd7: begin
                    op_wr = 1'b1;
                end
                default: begin
                    op_mode = M_PLAIN;
                end
            endcase
            run_op(op_wr, addr, d[WORD_W-1:0], op_mode);
            last_rd   = !op_wr;
            last_addr = addr;
        end

        $display("Run finished: %0d ops, %0d errors", n_ops, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen (
    output logic o_clk,
    output logic o_arst_n
);
    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 16;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Released one unit after the last reset edge
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_arst_n = 1'b1;
    end

endmodule

// File: hdl/cache_subsys_top.sv
module cache_subsys_top (
    input  logic                         clk,
    input  logic                         i_arst_n,
    input  logic                         i_read,
    input  logic                         i_write,
    input  logic [cache_pkg::WORD_W-1:0] i_addr,
    input  logic [cache_pkg::WORD_W-1:0] i_wdata,
    output logic [cache_pkg::WORD_W-1:0] o_rdata,
    output logic                         o_ready,
    output logic                         o_mem_read,
    output logic                         o_mem_write,
    output logic                         o_mem_line,
    output logic [cache_pkg::WORD_W-1:0] o_mem_addr
);
    import cache_pkg::*;

    // Controller to store
    logic [WORD_W-1:0] lookup_addr;
    logic              hit;
    line_t             hit_line;
    logic              fill;
    logic              touch;
    logic              merge;
    logic [WORD_W-1:0] merge_word;

    // Controller to memory
    line_t             mem_wdata;
    line_t             mem_rdata;
    logic              mem_ready;

    cache_ctrl u_ctrl (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_read        (i_read),
        .i_write       (i_write),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .i_hit         (hit),
        .i_hit_line    (hit_line),
        .i_mem_rdata   (mem_rdata),
        .i_mem_ready   (mem_ready),
        .o_rdata       (o_rdata),
        .o_ready       (o_ready),
        .o_lookup_addr (lookup_addr),
        .o_fill        (fill),
        .o_touch       (touch),
        .o_merge       (merge),
        .o_merge_word  (merge_word),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_mem_line    (o_mem_line),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wdata   (mem_wdata)
    );

    cache_store u_store (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_addr       (lookup_addr),
        .i_fill       (fill),
        .i_fill_line  (mem_rdata),
        .i_touch      (touch),
        .i_merge      (merge),
        .i_merge_word (merge_word),
        .o_hit        (hit),
        .o_hit_line   (hit_line)
    );

    // Memory sees the same request levels that leave the top
    line_memory u_mem (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_read   (o_mem_read),
        .i_write  (o_mem_write),
        .i_line   (o_mem_line),
        .i_addr   (o_mem_addr),
        .i_wdata  (mem_wdata),
        .o_rdata  (mem_rdata),
        .o_ready  (mem_ready)
    );

endmodule

// File: hdl/line_memory.sv
module line_memory (
    input  logic                         clk,
    input  logic                         i_arst_n,
    input  logic                         i_read,
    input  logic                         i_write,
    input  logic                         i_line,
    input  logic [cache_pkg::WORD_W-1:0] i_addr,
    input  cache_pkg::line_t             i_wdata,
    output cache_pkg::line_t             o_rdata,
    output logic                         o_ready
);
    import cache_pkg::*;

    // Full word-addressed space, starts cleared
    logic [WORD_W-1:0] mem [2**WORD_W] = '{default: '0};

    logic                                req;
    logic                                req_q;
    logic                                active_q;
    logic [$clog2(MEM_LATENCY + 1)-1:0]  cnt_q;
    logic                                start;
    logic                                done;

    // Request captured when its level rises
    logic                                is_read_q;
    logic                                is_line_q;
    logic [WORD_W-1:0]                   addr_q;
    line_t                               wdata_q;
    logic [WORD_W-1:0]                   line_base;

    assign req   = i_read || i_write;
    assign start = req && !req_q && !active_q;
    // Last busy cycle, the ready pulse follows
    assign done  = active_q && (cnt_q == ($bits(cnt_q))'(MEM_LATENCY - 1));

    assign line_base = {addr_q[WORD_W-1:OFF_MSB+1], {(OFF_MSB + 1){1'b0}}};

    // Latency counter and ready pulse
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            req_q    <= 1'b0;
            active_q <= 1'b0;
            cnt_q    <= '0;
            o_ready  <= 1'b0;
        end else begin
            req_q   <= req;
            o_ready <= 1'b0;
            if (done) begin
                active_q <= 1'b0;
                o_ready  <= 1'b1;
            end else if (active_q) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (start) begin
                active_q <= 1'b1;
                cnt_q    <= ($bits(cnt_q))'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_read_q <= i_read;
            is_line_q <= i_line;
            addr_q    <= i_addr;
            wdata_q   <= i_wdata;
        end
        if (done) begin
            if (is_read_q) begin
                for (int k = 0; k < LINE_WORDS; k++) begin
                    o_rdata.words[k] <= mem[line_base + WORD_W'(k)];
                end
            end else if (is_line_q) begin
                for (int k = 0; k < LINE_WORDS; k++) begin
                    mem[line_base + WORD_W'(k)] <= wdata_q.words[k];
                end
            end else begin
                mem[addr_q] <= wdata_q.words[0];
            end
        end
    end

    // Line reads and line writes arrive with the offset cleared
    a_line_aligned: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_read || (i_write && i_line)) |-> (i_addr[OFF_MSB:OFF_LSB] == '0)
    );

endmodule

// File: hdl/cache_ctrl.sv
module cache_ctrl (
    input  logic                         clk,
    input  logic                         i_arst_n,
    input  logic                         i_read,
    input  logic                         i_write,
    input  logic [cache_pkg::WORD_W-1:0] i_addr,
    input  logic [cache_pkg::WORD_W-1:0] i_wdata,
    input  logic                         i_hit,
    input  cache_pkg::line_t             i_hit_line,
    input  cache_pkg::line_t             i_mem_rdata,
    input  logic                         i_mem_ready,
    output logic [cache_pkg::WORD_W-1:0] o_rdata,
    output logic                         o_ready,
    output logic [cache_pkg::WORD_W-1:0] o_lookup_addr,
    output logic                         o_fill,
    output logic                         o_touch,
    output logic                         o_merge,
    output logic [cache_pkg::WORD_W-1:0] o_merge_word,
    output logic                         o_mem_read,
    output logic                         o_mem_write,
    output logic                         o_mem_line,
    output logic [cache_pkg::WORD_W-1:0] o_mem_addr,
    output cache_pkg::line_t             o_mem_wdata
);
    import cache_pkg::*;

    logic [ST_W-1:0]          state_q;
    // Background line write still waiting for its ready pulse
    logic                     wr_pending_q;

    // Latched request
    logic [WORD_W-1:0]        req_addr_q;
    logic [WORD_W-1:0]        req_wdata_q;
    logic                     req_write_q;

    logic [OFF_MSB-OFF_LSB:0] req_off;
    logic [WORD_W-1:0]        line_addr;
    line_t                    merged_line;
    logic                     accept;
    logic                     in_lookup;
    logic                     mem_free;
    logic                     read_hit;
    logic                     start_word;
    logic                     start_fill;

    assign req_off   = req_addr_q[OFF_MSB:OFF_LSB];
    assign line_addr = {req_addr_q[WORD_W-1:OFF_MSB+1], {(OFF_MSB + 1){1'b0}}};

    // Hit line with the new word dropped in, sent as the write-through beat
    always_comb begin
        merged_line = i_hit_line;
        merged_line.words[req_off] = req_wdata_q;
    end

    assign accept    = o_ready && (i_read || i_write);
    assign in_lookup = (state_q == ST_LOOKUP);
    // Memory can take a new request only with no line write in flight
    assign mem_free  = in_lookup && !wr_pending_q;

    assign read_hit   = in_lookup && i_hit && !req_write_q;
    assign start_word = mem_free && !i_hit && req_write_q;
    assign start_fill = mem_free && !i_hit && !req_write_q;

    // Store strobes
    assign o_lookup_addr = req_addr_q;
    assign o_touch       = read_hit;
    assign o_merge       = mem_free && i_hit && req_write_q;
    assign o_merge_word  = req_wdata_q;
    assign o_fill        = (state_q == ST_FILL) && i_mem_ready;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q      <= ST_IDLE;
            o_ready      <= 1'b1;
            wr_pending_q <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
        end else begin
            // Background line write completes in any state
            if (wr_pending_q && i_mem_ready) begin
                wr_pending_q <= 1'b0;
                o_mem_write  <= 1'b0;
            end

            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        o_ready <= 1'b0;
                        state_q <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (read_hit) begin
                        o_ready <= 1'b1;
                        state_q <= ST_IDLE;
                    end else if (o_merge) begin
                        // Write hit, line goes out in the background
                        o_mem_write  <= 1'b1;
                        wr_pending_q <= 1'b1;
                        o_ready      <= 1'b1;
                        state_q      <= ST_IDLE;
                    end else if (start_word) begin
                        o_mem_write <= 1'b1;
                        state_q     <= ST_WORD_WR;
                    end else if (start_fill) begin
                        o_mem_read <= 1'b1;
                        state_q    <= ST_FILL;
                    end else if (!i_mem_ready) begin
                        state_q <= ST_WAIT_WR;
                    end
                    // Pulse right now: level drops this edge, look up again next cycle
                end
                ST_WAIT_WR: begin
                    if (i_mem_ready) begin
                        state_q <= ST_LOOKUP;
                    end
                end
                ST_FILL: begin
                    if (i_mem_ready) begin
                        o_mem_read <= 1'b0;
                        o_ready    <= 1'b1;
                        state_q    <= ST_IDLE;
                    end
                end
                ST_WORD_WR: begin
                    if (i_mem_ready) begin
                        o_mem_write <= 1'b0;
                        o_ready     <= 1'b1;
                        state_q     <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Request latch, read data and memory request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q  <= i_addr;
            req_wdata_q <= i_wdata;
            req_write_q <= i_write;
        end
        if (read_hit) begin
            o_rdata <= i_hit_line.words[req_off];
        end else if (o_fill) begin
            o_rdata <= i_mem_rdata.words[req_off];
        end
        if (o_merge) begin
            o_mem_line  <= 1'b1;
            o_mem_addr  <= line_addr;
            o_mem_wdata <= merged_line;
        end else if (start_word) begin
            // Single word in the low bits, unaligned address
            o_mem_line      <= 1'b0;
            o_mem_addr      <= req_addr_q;
            o_mem_wdata.raw <= LINE_W'(req_wdata_q);
        end else if (start_fill) begin
            o_mem_line <= 1'b1;
            o_mem_addr <= line_addr;
        end
    end

    a_mem_excl: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        !(o_mem_read && o_mem_write)
    );

    // An outstanding request holds until memory answers it
    a_mem_hold: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_mem_read || o_mem_write) && !i_mem_ready
        |=> $stable({o_mem_read, o_mem_write, o_mem_line, o_mem_addr})
    );

    a_ready_idle: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (state_q != ST_IDLE) |-> !o_ready
    );

endmodule

// File: hdl/cache_store.sv
module cache_store (
    input  logic                         clk,
    input  logic                         i_arst_n,
    input  logic [cache_pkg::WORD_W-1:0] i_addr,
    input  logic                         i_fill,
    input  cache_pkg::line_t             i_fill_line,
    input  logic                         i_touch,
    input  logic                         i_merge,
    input  logic [cache_pkg::WORD_W-1:0] i_merge_word,
    output logic                         o_hit,
    output cache_pkg::line_t             o_hit_line
);
    import cache_pkg::*;

    // Tag and line arrays, indexed [set][way]
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];
    line_t               data_q  [NUM_SETS][NUM_WAYS];
    // Per set, the way that was used least recently
    logic [NUM_SETS-1:0] lru_q;

    logic                     idx;
    logic [TAG_W-1:0]         tag;
    logic [OFF_MSB-OFF_LSB:0] off;
    logic [NUM_WAYS-1:0]      way_hit;
    logic                     hit_way;
    logic                     victim;

    assign idx = i_addr[IDX_BIT];
    assign tag = i_addr[TAG_LSB +: TAG_W];
    assign off = i_addr[OFF_MSB:OFF_LSB];

    // Compare both ways of the indexed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[idx][w] && (tag_q[idx][w] == tag);
        end
    end

    assign o_hit      = |way_hit;
    assign hit_way    = way_hit[1];
    assign o_hit_line = data_q[idx][hit_way];

    // Victim choice: an empty way wins, then the LRU way
    always_comb begin
        if (!valid_q[idx][0]) begin
            victim = 1'b0;
        end else if (!valid_q[idx][1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[idx];
        end
    end

    // Valid and LRU state
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
            lru_q <= '0;
        end else if (i_fill) begin
            valid_q[idx][victim] <= 1'b1;
            // New line becomes most recent
            lru_q[idx] <= ~victim;
        end else if (i_touch || i_merge) begin
            lru_q[idx] <= ~hit_way;
        end
    end

    // Tags and line data
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_q[idx][victim]  <= tag;
            data_q[idx][victim] <= i_fill_line;
        end else if (i_merge) begin
            // Write hit keeps the line valid with the new word in place
            data_q[idx][hit_way].words[off] <= i_merge_word;
        end
    end

    // A fill must never duplicate a tag already resident in the set
    for (genvar s = 0; s < NUM_SETS; s++) begin : g_tag_chk
        a_unique_tag: assert property (
            @(posedge clk) disable iff (!i_arst_n)
            !(valid_q[s][0] && valid_q[s][1] && (tag_q[s][0] == tag_q[s][1]))
        );
    end

endmodule

// File: hdl/cache_pkg.sv
package cache_pkg;

    // Processor word and cache line geometry
    localparam int WORD_W     = 16;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = WORD_W * LINE_WORDS;

    // Word address fields: tag | index | offset
    localparam int OFF_LSB = 0;
    localparam int OFF_MSB = 1;
    localparam int IDX_BIT = 2;
    localparam int TAG_LSB = 3;
    localparam int TAG_W   = 13;

    localparam int NUM_SETS = 2;
    localparam int NUM_WAYS = 2;

    // Request level rise to ready pulse, in cycles
    localparam int MEM_LATENCY = 4;

    // Controller state encodings
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE    = 3'd0;
    localparam logic [ST_W-1:0] ST_LOOKUP  = 3'd1;
    localparam logic [ST_W-1:0] ST_WAIT_WR = 3'd2;
    localparam logic [ST_W-1:0] ST_FILL    = 3'd3;
    localparam logic [ST_W-1:0] ST_WORD_WR = 3'd4;

    // One cache line, seen either as a memory beat or as words
    // Word 0 occupies the low 16 bits
    typedef union packed {
        logic [LINE_W-1:0]                  raw;
        logic [LINE_WORDS-1:0][WORD_W-1:0]  words;
    } line_t;

endpackage
